// ==== rn_alu_pipe.sv ====
`default_nettype none

module rn_alu_pipe
  import rn_reg_pkg::*;
  import rn_inst_pkg::*;
#(
  parameter int ALU_STAGES = 2
)
(
  input  wire   clk,
  input  wire   rst_n,
  input  wire   in_vld_i,
  input  op_t   in_op_i,
  input  preg_t in_tag_i,
  input  data_t in_a_i,
  input  data_t in_b_i,
  input  imm_t  in_imm_i,
  output logic  wb_vld_o,
  output preg_t wb_tag_o,
  output data_t wb_data_o
);

  logic  vld_q [ALU_STAGES];
  preg_t tag_q [ALU_STAGES];
  data_t res_q [ALU_STAGES];
  data_t alu_res;

  // all ops wrap at 16 bits
  always_comb
  begin
    case (in_op_i)
      OP_ADD:  alu_res = in_a_i + in_b_i;
      OP_SUB:  alu_res = in_a_i - in_b_i;
      OP_XOR:  alu_res = in_a_i ^ in_b_i;
      default: alu_res = data_t'(in_imm_i);
    endcase
  end

  //////////////////////////////////////////////////
  // stage shift, never stalls
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int s = 0; s < ALU_STAGES; s++)
      begin
        vld_q[s] <= 1'b0;
      end
    end
    else
    begin
      vld_q[0] <= in_vld_i;
      for (int s = 1; s < ALU_STAGES; s++)
      begin
        vld_q[s] <= vld_q[s-1];
      end
    end
  end

  // result computed in stage 0, then carried along
  always_ff @(posedge clk)
  begin
    tag_q[0] <= in_tag_i;
    res_q[0] <= alu_res;
    for (int s = 1; s < ALU_STAGES; s++)
    begin
      tag_q[s] <= tag_q[s-1];
      res_q[s] <= res_q[s-1];
    end
  end

  assign wb_vld_o  = vld_q[ALU_STAGES-1];
  assign wb_tag_o  = tag_q[ALU_STAGES-1];
  assign wb_data_o = res_q[ALU_STAGES-1];

endmodule

`default_nettype wire

// ==== rn_core.sv ====
`default_nettype none

module rn_core
  import rn_reg_pkg::*;
  import rn_inst_pkg::*;
#(
  parameter int PREG_NUM   = 32,
  parameter int QDEPTH     = 8,
  parameter int ALU_STAGES = 2
)
(
  input  wire   clk,
  input  wire   rst_n,
  input  wire   disp_valid_i,
  output logic  disp_ready_o,
  input  op_t   disp_op_i,
  input  wire   disp_dst_vld_i,
  input  lreg_t disp_ldst_i,
  input  wire   disp_src1_vld_i,
  input  lreg_t disp_lsrc1_i,
  input  wire   disp_src2_vld_i,
  input  lreg_t disp_lsrc2_i,
  input  imm_t  disp_imm_i,
  output logic  ret_valid_o,
  input  wire   ret_ready_i,
  output logic  ret_has_dst_o,
  output lreg_t ret_ldst_o,
  output data_t ret_data_o
);

  // free list
  logic  alloc;
  logic  rel;
  preg_t rel_tag;
  preg_t free_tag;
  logic  free_empty;
  // issue
  logic  iss_vld;
  op_t   iss_op;
  preg_t iss_tag;
  imm_t  iss_imm;
  preg_t iss_src1;
  preg_t iss_src2;
  logic  iss_src1_vld;
  logic  iss_src2_vld;
  data_t rd1_data;
  data_t rd2_data;
  data_t alu_a;
  data_t alu_b;
  // writeback and retire
  logic  wb_vld;
  preg_t wb_tag;
  data_t wb_data;
  preg_t ret_tag;
  data_t rd3_data;

  // unused operands read as zero
  assign alu_a = iss_src1_vld ? rd1_data : '0;
  assign alu_b = iss_src2_vld ? rd2_data : '0;
  // no destination retires a zero value
  assign ret_data_o = ret_has_dst_o ? rd3_data : '0;

  rn_rename_queue #(
    .QDEPTH (QDEPTH)
  ) u_queue (
    .clk             (clk),
    .rst_n           (rst_n),
    .disp_valid_i    (disp_valid_i),
    .disp_ready_o    (disp_ready_o),
    .disp_op_i       (disp_op_i),
    .disp_dst_vld_i  (disp_dst_vld_i),
    .disp_ldst_i     (disp_ldst_i),
    .disp_src1_vld_i (disp_src1_vld_i),
    .disp_lsrc1_i    (disp_lsrc1_i),
    .disp_src2_vld_i (disp_src2_vld_i),
    .disp_lsrc2_i    (disp_lsrc2_i),
    .disp_imm_i      (disp_imm_i),
    .free_tag_i      (free_tag),
    .free_empty_i    (free_empty),
    .alloc_o         (alloc),
    .rel_o           (rel),
    .rel_tag_o       (rel_tag),
    .iss_vld_o       (iss_vld),
    .iss_op_o        (iss_op),
    .iss_tag_o       (iss_tag),
    .iss_imm_o       (iss_imm),
    .iss_src1_o      (iss_src1),
    .iss_src2_o      (iss_src2),
    .iss_src1_vld_o  (iss_src1_vld),
    .iss_src2_vld_o  (iss_src2_vld),
    .wb_vld_i        (wb_vld),
    .wb_tag_i        (wb_tag),
    .ret_tag_o       (ret_tag),
    .ret_valid_o     (ret_valid_o),
    .ret_has_dst_o   (ret_has_dst_o),
    .ret_ldst_o      (ret_ldst_o),
    .ret_ready_i     (ret_ready_i)
  );

  rn_free_list #(
    .PREG_NUM (PREG_NUM)
  ) u_free_list (
    .clk        (clk),
    .rst_n      (rst_n),
    .alloc_i    (alloc),
    .rel_i      (rel),
    .rel_tag_i  (rel_tag),
    .free_tag_o (free_tag),
    .empty_o    (free_empty)
  );

  rn_prf #(
    .PREG_NUM (PREG_NUM)
  ) u_prf (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd1_tag_i  (iss_src1),
    .rd2_tag_i  (iss_src2),
    .rd3_tag_i  (ret_tag),
    .rd1_data_o (rd1_data),
    .rd2_data_o (rd2_data),
    .rd3_data_o (rd3_data),
    .wr_en_i    (wb_vld),
    .wr_tag_i   (wb_tag),
    .wr_data_i  (wb_data)
  );

  rn_alu_pipe #(
    .ALU_STAGES (ALU_STAGES)
  ) u_alu (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_vld_i  (iss_vld),
    .in_op_i   (iss_op),
    .in_tag_i  (iss_tag),
    .in_a_i    (alu_a),
    .in_b_i    (alu_b),
    .in_imm_i  (iss_imm),
    .wb_vld_o  (wb_vld),
    .wb_tag_o  (wb_tag),
    .wb_data_o (wb_data)
  );

endmodule

`default_nettype wire

// ==== rn_free_list.sv ====
`default_nettype none

module rn_free_list
  import rn_reg_pkg::*;
#(
  parameter int PREG_NUM = 32
)
(
  input  wire   clk,
  input  wire   rst_n,
  input  wire   alloc_i,
  input  wire   rel_i,
  input  preg_t rel_tag_i,
  output preg_t free_tag_o,
  output logic  empty_o
);

  // pool holds every tag not in the base map
  // depth is a power of two so pointers wrap on their own
  localparam int FL_DEPTH = PREG_NUM - LREG_NUM;
  localparam int FP_W     = $clog2(FL_DEPTH);
  localparam int FC_W     = $clog2(FL_DEPTH + 1);

  preg_t           fl_mem [FL_DEPTH];
  logic [FP_W-1:0] rd_q;
  logic [FP_W-1:0] wr_q;
  logic [FC_W-1:0] cnt_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      // tags above the identity map start out free
      for (int i = 0; i < FL_DEPTH; i++)
      begin
        fl_mem[i] <= preg_t'(LREG_NUM + i);
      end
      rd_q  <= '0;
      wr_q  <= '0;
      cnt_q <= FC_W'(FL_DEPTH);
    end
    else
    begin
      // pop at dispatch
      if (alloc_i)
        rd_q <= rd_q + 1'b1;
      // push at retire
      if (rel_i)
      begin
        fl_mem[wr_q] <= rel_tag_i;
        wr_q         <= wr_q + 1'b1;
      end
      if (alloc_i && !rel_i)
        cnt_q <= cnt_q - 1'b1;
      else if (rel_i && !alloc_i)
        cnt_q <= cnt_q + 1'b1;
    end
  end

  // head tag visible in the same cycle
  assign free_tag_o = fl_mem[rd_q];
  assign empty_o    = (cnt_q == '0);

endmodule

`default_nettype wire

// ==== rn_inst_pkg.sv ====
`default_nettype none

package rn_inst_pkg;

  localparam int IMM_W = 16;

  // opcode encoding
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_XOR = 2'd2,
    OP_LI  = 2'd3
  } op_t;

  typedef logic [IMM_W-1:0] imm_t;

  //////////////////////////////////////////////////
  // queue line life cycle
  //////////////////////////////////////////////////

  // empty -> wait -> exec -> done -> empty
  // lines without a destination skip exec
  typedef enum logic [1:0] {
    LN_EMPTY = 2'd0,
    LN_WAIT  = 2'd1,
    LN_EXEC  = 2'd2,
    LN_DONE  = 2'd3
  } line_st_t;

endpackage

`default_nettype wire

// ==== rn_prf.sv ====
`default_nettype none

module rn_prf
  import rn_reg_pkg::*;
#(
  parameter int PREG_NUM = 32
)
(
  input  wire   clk,
  input  wire   rst_n,
  input  preg_t rd1_tag_i,
  input  preg_t rd2_tag_i,
  input  preg_t rd3_tag_i,
  output data_t rd1_data_o,
  output data_t rd2_data_o,
  output data_t rd3_data_o,
  input  wire   wr_en_i,
  input  preg_t wr_tag_i,
  input  data_t wr_data_i
);

  data_t regs [PREG_NUM];

  // architectural state starts at zero
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < PREG_NUM; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wr_en_i)
      regs[wr_tag_i] <= wr_data_i;
  end

  // two issue operands
  assign rd1_data_o = regs[rd1_tag_i];
  assign rd2_data_o = regs[rd2_tag_i];
  // retire value
  assign rd3_data_o = regs[rd3_tag_i];

endmodule

`default_nettype wire

// ==== rn_queue_line.sv ====
`default_nettype none

module rn_queue_line
  import rn_reg_pkg::*;
(
  input  wire      clk,
  input  wire      rst_n,
  input  wire      ld_i,
  input  wire      ld_dst_vld_i,
  input  lreg_t    ld_ldst_i,
  input  lreg_t    ld_lsrc1_i,
  input  lreg_t    ld_lsrc2_i,
  input  wire      ld_src1_vld_i,
  input  wire      ld_src2_vld_i,
  input  preg_t    ld_pdst_i,
  input  wire      dst_rdy_en_i,
  input  wire      dst_rdy_i,
  input  map_bus_t prv_map_i,
  output map_bus_t cur_map_o,
  output map_ent_t psrc1_o,
  output map_ent_t psrc2_o,
  output logic     inst_rdy_o,
  output preg_t    fre_preg_o,
  output logic     has_dst_o
);

  // stored register fields
  logic     dst_vld_q;
  logic     src1_vld_q;
  logic     src2_vld_q;
  lreg_t    ldst_q;
  lreg_t    lsrc1_q;
  lreg_t    lsrc2_q;
  preg_t    pdst_q;
  logic     dst_rdy_q;
  map_ent_t src1_ent;
  map_ent_t src2_ent;
  map_ent_t dst_old;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      dst_vld_q  <= 1'b0;
      src1_vld_q <= 1'b0;
      src2_vld_q <= 1'b0;
    end
    else if (ld_i)
    begin
      dst_vld_q  <= ld_dst_vld_i;
      src1_vld_q <= ld_src1_vld_i;
      src2_vld_q <= ld_src2_vld_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (ld_i)
    begin
      ldst_q  <= ld_ldst_i;
      lsrc1_q <= ld_lsrc1_i;
      lsrc2_q <= ld_lsrc2_i;
      pdst_q  <= ld_pdst_i;
    end
  end

  //////////////////////////////////////////////////
  // destination ready flop
  //////////////////////////////////////////////////

  // load blocks younger readers, writeback releases them
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      dst_rdy_q <= 1'b0;
    else if (ld_i)
      dst_rdy_q <= 1'b0;
    else if (dst_rdy_en_i)
      dst_rdy_q <= dst_rdy_i;
  end

  //////////////////////////////////////////////////
  // source rename from the incoming map
  //////////////////////////////////////////////////

  assign src1_ent = map_get(prv_map_i, lsrc1_q);
  assign src2_ent = map_get(prv_map_i, lsrc2_q);

  // unused source counts as ready, tag 0
  assign psrc1_o = src1_vld_q ? src1_ent : {1'b1, {PREG_W{1'b0}}};
  assign psrc2_o = src2_vld_q ? src2_ent : {1'b1, {PREG_W{1'b0}}};

  assign inst_rdy_o = psrc1_o[PREG_W] & psrc2_o[PREG_W];

  // old mapping of ldst is freed when this line retires
  assign dst_old    = map_get(prv_map_i, ldst_q);
  assign fre_preg_o = dst_old[PREG_W-1:0];
  assign has_dst_o  = dst_vld_q;

  // outgoing map, own destination overrides
  assign cur_map_o = dst_vld_q ? map_set(prv_map_i, ldst_q, {dst_rdy_q, pdst_q})
                               : prv_map_i;

endmodule

`default_nettype wire

// ==== rn_reg_pkg.sv ====
`default_nettype none

package rn_reg_pkg;

  // logical register space
  localparam int LREG_NUM = 16;
  localparam int LREG_W   = 4;

  // physical tag width, 32 physical registers
  localparam int PREG_W = 5;
  // map entry is ready bit on top of the tag
  localparam int ENT_W  = PREG_W + 1;
  localparam int MAP_W  = LREG_NUM * ENT_W;
  localparam int DATA_W = 16;

  typedef logic [LREG_W-1:0] lreg_t;
  typedef logic [PREG_W-1:0] preg_t;
  typedef logic [ENT_W-1:0]  map_ent_t;
  // logical register 0 sits in the low bits
  typedef logic [MAP_W-1:0]  map_bus_t;
  typedef logic [DATA_W-1:0] data_t;

  //////////////////////////////////////////////////
  // map helpers
  //////////////////////////////////////////////////

  // identity mapping, everything ready
  function automatic map_bus_t reset_map();
    map_bus_t m;
    for (int i = 0; i < LREG_NUM; i++)
    begin
      m[i*ENT_W +: ENT_W] = {1'b1, preg_t'(i)};
    end
    return m;
  endfunction

  function automatic map_ent_t map_get(map_bus_t m, lreg_t l);
    return m[l*ENT_W +: ENT_W];
  endfunction

  function automatic map_bus_t map_set(map_bus_t m, lreg_t l, map_ent_t e);
    map_bus_t r;
    r = m;
    r[l*ENT_W +: ENT_W] = e;
    return r;
  endfunction

  // committed state has no pending producers
  function automatic map_bus_t map_all_rdy(map_bus_t m);
    map_bus_t r;
    r = m;
    for (int i = 0; i < LREG_NUM; i++)
    begin
      r[i*ENT_W + PREG_W] = 1'b1;
    end
    return r;
  endfunction

endpackage

`default_nettype wire

// ==== rn_rename_queue.sv ====
`default_nettype none

module rn_rename_queue
  import rn_reg_pkg::*;
  import rn_inst_pkg::*;
#(
  parameter int QDEPTH = 8
)
(
  input  wire   clk,
  input  wire   rst_n,
  input  wire   disp_valid_i,
  output logic  disp_ready_o,
  input  op_t   disp_op_i,
  input  wire   disp_dst_vld_i,
  input  lreg_t disp_ldst_i,
  input  wire   disp_src1_vld_i,
  input  lreg_t disp_lsrc1_i,
  input  wire   disp_src2_vld_i,
  input  lreg_t disp_lsrc2_i,
  input  imm_t  disp_imm_i,
  input  preg_t free_tag_i,
  input  wire   free_empty_i,
  output logic  alloc_o,
  output logic  rel_o,
  output preg_t rel_tag_o,
  output logic  iss_vld_o,
  output op_t   iss_op_o,
  output preg_t iss_tag_o,
  output imm_t  iss_imm_o,
  output preg_t iss_src1_o,
  output preg_t iss_src2_o,
  output logic  iss_src1_vld_o,
  output logic  iss_src2_vld_o,
  input  wire   wb_vld_i,
  input  preg_t wb_tag_i,
  output preg_t ret_tag_o,
  output logic  ret_valid_o,
  output logic  ret_has_dst_o,
  output lreg_t ret_ldst_o,
  input  wire   ret_ready_i
);

  localparam int PTR_W = $clog2(QDEPTH);

  // per line control and payload
  line_st_t q_st   [QDEPTH];
  op_t      q_op   [QDEPTH];
  imm_t     q_imm  [QDEPTH];
  lreg_t    q_ldst [QDEPTH];
  preg_t    q_pdst [QDEPTH];
  logic     q_s1v  [QDEPTH];
  logic     q_s2v  [QDEPTH];

  logic [PTR_W-1:0] head_q;
  logic [PTR_W-1:0] iss_q;
  logic [PTR_W-1:0] tail_q;
  map_bus_t         base_map_q;

  // chain and line outputs
  map_bus_t prv_map  [QDEPTH];
  map_bus_t cur_map  [QDEPTH];
  map_ent_t psrc1    [QDEPTH];
  map_ent_t psrc2    [QDEPTH];
  logic     line_rdy [QDEPTH];
  preg_t    fre_preg [QDEPTH];
  logic     line_dst [QDEPTH];
  logic     wb_hit   [QDEPTH];

  logic disp_fire;
  logic iss_fire;
  logic ret_fire;

  //////////////////////////////////////////////////
  // handshakes
  //////////////////////////////////////////////////

  // need a free line, and a free tag when writing a register
  assign disp_ready_o = (q_st[tail_q] == LN_EMPTY) && (!disp_dst_vld_i || !free_empty_i);
  assign disp_fire    = disp_valid_i && disp_ready_o;
  assign alloc_o      = disp_fire && disp_dst_vld_i;

  // in order issue from the issue pointer
  assign iss_fire       = (q_st[iss_q] == LN_WAIT) && line_rdy[iss_q];
  // lines without a destination never enter the ALU
  assign iss_vld_o      = iss_fire && line_dst[iss_q];
  assign iss_op_o       = q_op[iss_q];
  assign iss_tag_o      = q_pdst[iss_q];
  assign iss_imm_o      = q_imm[iss_q];
  assign iss_src1_o     = psrc1[iss_q][PREG_W-1:0];
  assign iss_src2_o     = psrc2[iss_q][PREG_W-1:0];
  assign iss_src1_vld_o = q_s1v[iss_q];
  assign iss_src2_vld_o = q_s2v[iss_q];

  // retire from the head
  assign ret_valid_o   = (q_st[head_q] == LN_DONE);
  assign ret_fire      = ret_valid_o && ret_ready_i;
  assign ret_has_dst_o = line_dst[head_q];
  assign ret_ldst_o    = q_ldst[head_q];
  assign ret_tag_o     = q_pdst[head_q];
  assign rel_o         = ret_fire && line_dst[head_q];
  assign rel_tag_o     = fre_preg[head_q];

  //////////////////////////////////////////////////
  // lines and map chain
  //////////////////////////////////////////////////

  for (genvar g = 0; g < QDEPTH; g++)
  begin : g_line
    localparam int PRV = (g == 0) ? QDEPTH - 1 : g - 1;

    // head starts from the committed map, the rest from the older line
    assign prv_map[g] = (head_q == PTR_W'(g)) ? base_map_q : cur_map[PRV];
    // only an executing line can own the written tag
    assign wb_hit[g]  = wb_vld_i && (q_st[g] == LN_EXEC) && (q_pdst[g] == wb_tag_i);

    rn_queue_line u_line (
      .clk           (clk),
      .rst_n         (rst_n),
      .ld_i          (disp_fire && (tail_q == PTR_W'(g))),
      .ld_dst_vld_i  (disp_dst_vld_i),
      .ld_ldst_i     (disp_ldst_i),
      .ld_lsrc1_i    (disp_lsrc1_i),
      .ld_lsrc2_i    (disp_lsrc2_i),
      .ld_src1_vld_i (disp_src1_vld_i),
      .ld_src2_vld_i (disp_src2_vld_i),
      .ld_pdst_i     (free_tag_i),
      .dst_rdy_en_i  (wb_hit[g]),
      .dst_rdy_i     (1'b1),
      .prv_map_i     (prv_map[g]),
      .cur_map_o     (cur_map[g]),
      .psrc1_o       (psrc1[g]),
      .psrc2_o       (psrc2[g]),
      .inst_rdy_o    (line_rdy[g]),
      .fre_preg_o    (fre_preg[g]),
      .has_dst_o     (line_dst[g])
    );
  end

  //////////////////////////////////////////////////
  // pointers, states, base map
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      head_q     <= '0;
      iss_q      <= '0;
      tail_q     <= '0;
      base_map_q <= reset_map();
      for (int i = 0; i < QDEPTH; i++)
      begin
        q_st[i] <= LN_EMPTY;
      end
    end
    else
    begin
      if (disp_fire)
        tail_q <= tail_q + 1'b1;
      if (iss_fire)
        iss_q <= iss_q + 1'b1;
      if (ret_fire)
      begin
        head_q     <= head_q + 1'b1;
        base_map_q <= map_all_rdy(cur_map[head_q]);
      end
      for (int i = 0; i < QDEPTH; i++)
      begin
        if (disp_fire && (tail_q == PTR_W'(i)))
          q_st[i] <= LN_WAIT;
        else if (iss_fire && (iss_q == PTR_W'(i)))
          q_st[i] <= line_dst[i] ? LN_EXEC : LN_DONE;
        else if (wb_hit[i])
          q_st[i] <= LN_DONE;
        else if (ret_fire && (head_q == PTR_W'(i)))
          q_st[i] <= LN_EMPTY;
      end
    end
  end

  // instruction payload captured at dispatch
  always_ff @(posedge clk)
  begin
    if (disp_fire)
    begin
      q_op[tail_q]   <= disp_op_i;
      q_imm[tail_q]  <= disp_imm_i;
      q_ldst[tail_q] <= disp_ldst_i;
      q_pdst[tail_q] <= free_tag_i;
      q_s1v[tail_q]  <= disp_src1_vld_i;
      q_s2v[tail_q]  <= disp_src2_vld_i;
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
rn_reg_pkg.sv
rn_inst_pkg.sv
rn_queue_line.sv
rn_free_list.sv
rn_prf.sv
rn_alu_pipe.sv
rn_rename_queue.sv
rn_core.sv
tb_rn_core.sv

// ==== tb_rn_tasks.svh ====
`ifndef TB_RN_TASKS_SVH
`define TB_RN_TASKS_SVH

//////////////////////////////////////////////////
// random numbers and clocking
//////////////////////////////////////////////////

// 32 bit xorshift, shifts 13 17 5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

function automatic logic [31:0] next_rand();
  rnd_state = xorshift32(rnd_state);
  return rnd_state;
endfunction

// one cycle, inputs change just after the rising edge
task automatic step();
  logic [31:0] r;
  @(posedge clk);
  #1;
  if (rand_ready)
  begin
    r = next_rand();
    ret_ready_i = r[7];
  end
endtask

//////////////////////////////////////////////////
// checking model
//////////////////////////////////////////////////

task automatic check_val(input string what, input logic [31:0] exp_v,
                         input logic [31:0] act_v);
  if (exp_v !== act_v)
  begin
    $display("Fail %s %s: expected %0h, actual %0h", cur_test, what, exp_v, act_v);
    err_cnt++;
  end
endtask

function automatic data_t expected_result(input op_t op, input data_t a, input data_t b,
                                          input imm_t imm);
  case (op)
    OP_ADD:  return a + b;
    OP_SUB:  return a - b;
    OP_XOR:  return a ^ b;
    default: return imm;
  endcase
endfunction

// accepted instruction in program order, update state and queue the retire
task automatic model_dispatch(input op_t op, input logic dv, input lreg_t ld,
                              input logic s1v, input lreg_t ls1,
                              input logic s2v, input lreg_t ls2, input imm_t imm);
  data_t a;
  data_t b;
  data_t res;
  // an unused source reads as zero
  a   = s1v ? arch_val[ls1] : '0;
  b   = s2v ? arch_val[ls2] : '0;
  res = dv ? expected_result(op, a, b, imm) : '0;
  if (dv)
    arch_val[ld] = res;
  exp_has_q.push_back(dv);
  exp_ldst_q.push_back(ld);
  exp_data_q.push_back(res);
endtask

//////////////////////////////////////////////////
// dispatch and waits
//////////////////////////////////////////////////

// one attempt, decided by disp_ready_o in the middle of the cycle
task automatic try_dispatch(input op_t op, input logic dv, input lreg_t ld,
                            input logic s1v, input lreg_t ls1,
                            input logic s2v, input lreg_t ls2, input imm_t imm,
                            output logic accepted);
  disp_valid_i    = 1'b1;
  disp_op_i       = op;
  disp_dst_vld_i  = dv;
  disp_ldst_i     = ld;
  disp_src1_vld_i = s1v;
  disp_lsrc1_i    = ls1;
  disp_src2_vld_i = s2v;
  disp_lsrc2_i    = ls2;
  disp_imm_i      = imm;
  @(negedge clk);
  accepted = disp_ready_o;
  if (accepted)
    model_dispatch(op, dv, ld, s1v, ls1, s2v, ls2, imm);
  step();
  disp_valid_i = 1'b0;
endtask

task automatic dispatch_inst(input op_t op, input logic dv, input lreg_t ld,
                             input logic s1v, input lreg_t ls1,
                             input logic s2v, input lreg_t ls2, input imm_t imm);
  logic accepted;
  int   waited;
  accepted = 1'b0;
  waited   = 0;
  while (!accepted && waited < TIMEOUT)
  begin
    try_dispatch(op, dv, ld, s1v, ls1, s2v, ls2, imm, accepted);
    waited++;
  end
  if (!accepted)
    report_timeout("dispatch was never accepted");
endtask

task automatic load_imm(input lreg_t ld, input imm_t imm);
  dispatch_inst(OP_LI, 1'b1, ld, 1'b0, '0, 1'b0, '0, imm);
endtask

task automatic alu_op(input op_t op, input lreg_t ld, input lreg_t ls1, input lreg_t ls2);
  dispatch_inst(op, 1'b1, ld, 1'b1, ls1, 1'b1, ls2, '0);
endtask

// every queued retire must come out
task automatic wait_drain();
  int waited;
  waited = 0;
  while (exp_has_q.size() != 0 && waited < TIMEOUT)
  begin
    step();
    waited++;
  end
  if (exp_has_q.size() != 0)
    report_timeout("instructions did not retire");
endtask

task automatic wait_ret_valid();
  logic seen;
  int   waited;
  seen   = 1'b0;
  waited = 0;
  while (!seen && waited < TIMEOUT)
  begin
    @(negedge clk);
    seen = ret_valid_o;
    step();
    waited++;
  end
  if (!seen)
    report_timeout("head never became ready to retire");
endtask

`endif

// ==== tb_rn_core.sv ====
`default_nettype none

module tb_rn_core
  import rn_reg_pkg::*;
  import rn_inst_pkg::*;
();

  localparam int QDEPTH     = 8;
  localparam int ALU_STAGES = 2;
  localparam int TIMEOUT    = 2000;

  logic  clk;
  logic  rst_n;
  logic  disp_valid_i;
  logic  disp_ready_o;
  op_t   disp_op_i;
  logic  disp_dst_vld_i;
  lreg_t disp_ldst_i;
  logic  disp_src1_vld_i;
  lreg_t disp_lsrc1_i;
  logic  disp_src2_vld_i;
  lreg_t disp_lsrc2_i;
  imm_t  disp_imm_i;
  logic  ret_valid_o;
  logic  ret_ready_i;
  logic  ret_has_dst_o;
  lreg_t ret_ldst_o;
  data_t ret_data_o;

  // architectural values and expected retires in program order
  data_t       arch_val [LREG_NUM];
  logic        exp_has_q [$];
  lreg_t       exp_ldst_q [$];
  data_t       exp_data_q [$];
  logic [31:0] rnd_state;
  logic        rand_ready;
  string       cur_test;
  int          err_cnt;
  int          test_err0;
  int          tests_run;
  int          tests_failed;
  int          ret_cnt;

  always #5 clk = ~clk;

  rn_core #(
    .PREG_NUM   (32),
    .QDEPTH     (QDEPTH),
    .ALU_STAGES (ALU_STAGES)
  ) rn_core_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .disp_valid_i    (disp_valid_i),
    .disp_ready_o    (disp_ready_o),
    .disp_op_i       (disp_op_i),
    .disp_dst_vld_i  (disp_dst_vld_i),
    .disp_ldst_i     (disp_ldst_i),
    .disp_src1_vld_i (disp_src1_vld_i),
    .disp_lsrc1_i    (disp_lsrc1_i),
    .disp_src2_vld_i (disp_src2_vld_i),
    .disp_lsrc2_i    (disp_lsrc2_i),
    .disp_imm_i      (disp_imm_i),
    .ret_valid_o     (ret_valid_o),
    .ret_ready_i     (ret_ready_i),
    .ret_has_dst_o   (ret_has_dst_o),
    .ret_ldst_o      (ret_ldst_o),
    .ret_data_o      (ret_data_o)
  );

  `include "tb_rn_tasks.svh"

  task automatic report_timeout(input string what);
    $display("Error: timeout in test %s, %s", cur_test, what);
    err_cnt++;
  endtask

  //////////////////////////////////////////////////
  // retire monitor
  //////////////////////////////////////////////////

  // mid cycle, the handshake for the next edge is settled
  always @(negedge clk)
  begin
    if (rst_n && ret_valid_o && ret_ready_i)
    begin
      ret_cnt++;
      if (exp_has_q.size() == 0)
      begin
        $display("Error: test %s saw a retire with nothing outstanding", cur_test);
        err_cnt++;
      end
      else
      begin
        check_val("retire has_dst", exp_has_q[0], ret_has_dst_o);
        // the logical number only carries meaning with a destination
        if (exp_has_q[0])
          check_val("retire ldst", exp_ldst_q[0], ret_ldst_o);
        check_val("retire data", exp_data_q[0], ret_data_o);
        void'(exp_has_q.pop_front());
        void'(exp_ldst_q.pop_front());
        void'(exp_data_q.pop_front());
      end
    end
  end

  task automatic start_test(input string name);
    cur_test  = name;
    test_err0 = err_cnt;
  endtask

  task automatic finish_test();
    int n;
    n = err_cnt - test_err0;
    tests_run++;
    if (n != 0)
      tests_failed++;
    $display("test %s: %s, %0d errors", cur_test, (n == 0) ? "ok" : "failed", n);
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic test_reset_fill();
    start_test("reset_fill");
    @(negedge clk);
    check_val("disp_ready_o after reset", 1, disp_ready_o);
    check_val("ret_valid_o after reset", 0, ret_valid_o);
    step();
    for (int i = 0; i < LREG_NUM; i++)
    begin
      load_imm(lreg_t'(i), imm_t'(16'h1000 + i * 16'h0111));
    end
    wait_drain();
    finish_test();
  endtask

  // each result feeds the next instruction
  task automatic test_dep_chain();
    op_t ops [3];
    ops = '{OP_ADD, OP_SUB, OP_XOR};
    start_test("dep_chain");
    load_imm(4'd1, 16'h1234);
    load_imm(4'd0, 16'h0f0f);
    for (int i = 1; i < 10; i++)
    begin
      alu_op(ops[i % 3], lreg_t'(i + 1), lreg_t'(i), lreg_t'(i - 1));
    end
    wait_drain();
    finish_test();
  endtask

  // same logical register written again and again, readers in between
  task automatic test_rename_hazard();
    start_test("rename_hazard");
    for (int k = 0; k < 3; k++)
    begin
      load_imm(4'd7, imm_t'(16'h00a5 + k * 16'h1111));
      alu_op(OP_ADD, 4'd8, 4'd7, 4'd0);
      load_imm(4'd7, imm_t'(16'hc003 - k * 16'h0101));
      alu_op(OP_XOR, 4'd9, 4'd7, 4'd8);
      alu_op(OP_ADD, 4'd7, 4'd7, 4'd9);
      alu_op(OP_SUB, 4'd10, 4'd7, 4'd8);
      alu_op(OP_ADD, 4'd7, 4'd7, 4'd7);
    end
    wait_drain();
    finish_test();
  endtask

  task automatic test_back_pressure();
    int   n_acc;
    int   limit;
    logic acc;
    logic full;
    start_test("back_pressure");
    limit       = (QDEPTH < 16) ? QDEPTH : 16;
    n_acc       = 0;
    full        = 1'b0;
    ret_ready_i = 1'b0;
    while (!full && n_acc < 64)
    begin
      // odd slots read the previous result
      try_dispatch(n_acc[0] ? OP_ADD : OP_LI, 1'b1, lreg_t'(n_acc),
                   1'b1, lreg_t'(n_acc - 1), 1'b1, lreg_t'(n_acc - 1),
                   imm_t'(16'h0300 + n_acc), acc);
      if (acc)
        n_acc++;
      else
        full = 1'b1;
    end
    check_val("dispatch stalled", 1, full);
    check_val("accepted within limit", 1, n_acc <= limit);
    wait_ret_valid();
    @(negedge clk);
    check_val("disp_ready_o while full", 0, disp_ready_o);
    step();
    ret_ready_i = 1'b1;
    wait_drain();
    // the queue takes work again
    load_imm(4'd2, 16'h5aa5);
    alu_op(OP_SUB, 4'd3, 4'd2, 4'd1);
    wait_drain();
    finish_test();
  endtask

  task automatic test_no_dst_invalid();
    start_test("no_dst_invalid");
    load_imm(4'd1, 16'h00ff);
    load_imm(4'd2, 16'h0f0f);
    dispatch_inst(OP_ADD, 1'b0, 4'd3, 1'b1, 4'd1, 1'b1, 4'd2, '0);
    dispatch_inst(OP_ADD, 1'b1, 4'd3, 1'b1, 4'd1, 1'b0, 4'd2, '0);
    dispatch_inst(OP_SUB, 1'b1, 4'd4, 1'b0, 4'd1, 1'b1, 4'd2, '0);
    dispatch_inst(OP_XOR, 1'b1, 4'd5, 1'b0, 4'd1, 1'b0, 4'd2, '0);
    // sources of a load-immediate are ignored
    dispatch_inst(OP_LI, 1'b1, 4'd6, 1'b1, 4'd4, 1'b1, 4'd5, 16'h7e57);
    dispatch_inst(OP_LI, 1'b0, 4'd1, 1'b0, 4'd0, 1'b0, 4'd0, 16'hdead);
    alu_op(OP_ADD, 4'd7, 4'd1, 4'd3);
    alu_op(OP_XOR, 4'd8, 4'd6, 4'd4);
    wait_drain();
    finish_test();
  endtask

  task automatic test_random();
    logic [31:0] r;
    start_test("random");
    rand_ready = 1'b1;
    for (int k = 0; k < 200; k++)
    begin
      r = next_rand();
      // mostly with a destination, sources valid three times in four
      dispatch_inst(op_t'(r[1:0]), r[4:2] != 3'd0, r[8:5], r[9] | r[10], r[14:11],
                    r[15] | r[16], r[20:17], r[31:16]);
    end
    wait_drain();
    rand_ready  = 1'b0;
    ret_ready_i = 1'b1;
    finish_test();
  endtask

  initial
  begin
    clk             = 1'b0;
    rst_n           = 1'b0;
    disp_valid_i    = 1'b0;
    disp_op_i       = OP_ADD;
    disp_dst_vld_i  = 1'b0;
    disp_ldst_i     = '0;
    disp_src1_vld_i = 1'b0;
    disp_lsrc1_i    = '0;
    disp_src2_vld_i = 1'b0;
    disp_lsrc2_i    = '0;
    disp_imm_i      = '0;
    ret_ready_i     = 1'b0;
    rnd_state       = 32'hae5134fb;
    rand_ready      = 1'b0;
    cur_test        = "reset";
    err_cnt         = 0;
    test_err0       = 0;
    tests_run       = 0;
    tests_failed    = 0;
    ret_cnt         = 0;
    for (int i = 0; i < LREG_NUM; i++)
    begin
      arch_val[i] = '0;
    end
    repeat (3) @(posedge clk);
    #1;
    rst_n       = 1'b1;
    ret_ready_i = 1'b1;
    test_reset_fill();
    test_dep_chain();
    test_rename_hazard();
    test_back_pressure();
    test_no_dst_invalid();
    test_random();
    $display("tests %0d, failed %0d, errors %0d, retired %0d",
             tests_run, tests_failed, err_cnt, ret_cnt);
    if (err_cnt == 0 && tests_failed == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
